// ==== files.f ====
+incdir+tests
src/mist_cfg_pkg.sv
src/mist_video_pkg.sv
src/mist_spi_rx.sv
src/mist_user_io.sv
src/mist_data_io.sv
src/mist_osd.sv
src/rgb2ypbpr.sv
src/mist_video_out.sv
src/sigma_delta_dac.sv
src/jtgng_mist_base.sv
tests/tb_mist_base.sv

// ==== Makefile ====
# Verilator build and run of the MiST base board testbench

TOP := tb_mist_base

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f src/*.sv tests/*.sv tests/*.svh
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_mist_spi.svh ====
// SPI mode 0 master tasks, 8 clk_sys cycles per bit, MSB first
// channel 0 is CONF_DATA0, 1 is SPI_SS2, 2 is SPI_SS3; payload comes from tx_q
`ifndef TB_MIST_SPI_SVH
`define TB_MIST_SPI_SVH

task automatic shift_byte(input logic [7:0] b);
   for (int i = 7; i >= 0; i--) begin
      spi_di = b[i];
      repeat (4) @(negedge clk);
      spi_sck = 1'b1;
      repeat (4) @(negedge clk);
      spi_sck = 1'b0;
   end
endtask

task automatic select_channel(input int ch);
   case (ch)
      0: conf_data0 = 1'b0;
      1: spi_ss2    = 1'b0;
      default: spi_ss3 = 1'b0;
   endcase
   repeat (4) @(negedge clk);
endtask

task automatic release_channel();
   // let the last byte through the synchronisers first
   repeat (8) @(negedge clk);
   conf_data0 = 1'b1;
   spi_ss2    = 1'b1;
   spi_ss3    = 1'b1;
   repeat (8) @(negedge clk);
endtask

task automatic send_command(input int ch, input logic [7:0] cmd);
   select_channel(ch);
   shift_byte(cmd);
   foreach (tx_q[i]) begin
      shift_byte(tx_q[i]);
   end
   tx_q.delete();
   release_channel();
endtask

`endif

// ==== tests/tb_mist_base.sv ====
// testbench for the MiST base board, runs with the default parameters
// OSD window at 16,8; expected video comes from a pipeline model kept here
`timescale 1ns/1ps

module tb_mist_base;

   // SPI bytes, commands, video cycles and DAC cycles of the whole run
   localparam int RUN_CYCLES = 110 * 64 + 11 * 20 + (6 + 6 + 20) * 100 * 2 + 2 * 1088 + 100;
   localparam int TIMEOUT_CYCLES = RUN_CYCLES * 5 / 4;

   logic        clk, rst_n, pxl_cen;
   logic [3:0]  game_r, game_g, game_b;
   logic        hs, vs, vga_hs, vga_vs;
   logic [5:0]  vga_r, vga_g, vga_b;
   logic        spi_di, spi_sck, spi_ss2, spi_ss3, conf_data0;
   logic [15:0] snd;
   logic [5:0]  video_r, video_g, video_b;
   logic        video_hs, video_vs, snd_pwm, ioctl_wr, downloading;
   logic [31:0] status, joy1, joy2;
   logic [21:0] ioctl_addr;
   logic [7:0]  ioctl_data;

   int          seed = 32'h7f77_afe6;
   int          err_cnt = 0;
   int          chk_cnt = 0;
   int          cycles = 0;
   int          wr_cnt = 0;
   logic [7:0]  tx_q[$];
   logic [7:0]  dl_q[$];
   logic [7:0]  bm [64];
   logic        mode_ypbpr = 1'b0;
   logic        mode_sd = 1'b0;
   logic        osd_on = 1'b0;
   logic        vid_chk = 1'b0;

   // reference pipeline: source select, OSD, output stage
   logic [5:0]  s1_r, s1_g, s1_b, s2_r, s2_g, s2_b, exp_r, exp_g, exp_b;
   logic        s1_hs, s1_vs, s2_hs, s2_vs, exp_hs, exp_vs;
   int          x_cnt, y_cnt;

   `include "tb_mist_spi.svh"

   jtgng_mist_base DUT (
      .clk_sys_i (clk), .rst_n_i (rst_n), .pxl_cen_i (pxl_cen),
      .game_r_i (game_r), .game_g_i (game_g), .game_b_i (game_b),
      .hs_i (hs), .vs_i (vs),
      .vga_r_i (vga_r), .vga_g_i (vga_g), .vga_b_i (vga_b),
      .vga_hsync_i (vga_hs), .vga_vsync_i (vga_vs),
      .spi_di_i (spi_di), .spi_sck_i (spi_sck), .spi_ss2_i (spi_ss2),
      .spi_ss3_i (spi_ss3), .conf_data0_i (conf_data0),
      .video_r_o (video_r), .video_g_o (video_g), .video_b_o (video_b),
      .video_hs_o (video_hs), .video_vs_o (video_vs),
      .status_o (status), .joystick1_o (joy1), .joystick2_o (joy2),
      .snd_i (snd), .snd_pwm_o (snd_pwm),
      .ioctl_addr_o (ioctl_addr), .ioctl_data_o (ioctl_data),
      .ioctl_wr_o (ioctl_wr), .downloading_o (downloading)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(negedge clk) begin
      if (rst_n) pxl_cen <= ~pxl_cen;
   end

   always @(posedge clk) begin
      cycles++;
   end

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      err_cnt++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
   endtask

   task automatic report_text(input string msg);
      err_cnt++;
      $display("error: %s at %0t", msg, $time);
   endtask

   // Y from the weighted sum, Pb and Pr offset by 32 and clamped
   task automatic ypbpr_ref(input int r, input int g, input int b,
                            output int y, output int pb, output int pr);
      y  = (r + 2 * g + b) / 4;
      pb = 32 + ((b - y) >>> 1);
      pr = 32 + ((r - y) >>> 1);
      if (pb < 0) pb = 0;
      if (pb > 63) pb = 63;
      if (pr < 0) pr = 0;
      if (pr > 63) pr = 63;
   endtask

   always @(posedge clk or negedge rst_n) begin : model
      int  px, py, y, pb, pr;
      logic fall_h, fall_v, lit;
      if (!rst_n) begin
         {s1_r, s1_g, s1_b, s1_hs, s1_vs} <= '0;
         {s2_r, s2_g, s2_b, s2_hs, s2_vs} <= '0;
         {exp_r, exp_g, exp_b, exp_hs, exp_vs} <= '0;
         x_cnt <= 0;
         y_cnt <= 0;
      end else if (pxl_cen) begin
         s1_r  <= mode_sd ? {game_r, game_r[3:2]} : vga_r;
         s1_g  <= mode_sd ? {game_g, game_g[3:2]} : vga_g;
         s1_b  <= mode_sd ? {game_b, game_b[3:2]} : vga_b;
         s1_hs <= mode_sd ? ~hs : vga_hs;
         s1_vs <= mode_sd ? ~vs : vga_vs;
         fall_h = s2_hs & ~s1_hs;
         fall_v = s2_vs & ~s1_vs;
         px = fall_h ? 0 : x_cnt;
         py = fall_v ? 0 : (fall_h ? (y_cnt + 1) % 1024 : y_cnt);
         x_cnt <= (px + 1) % 1024;
         y_cnt <= py;
         s2_hs <= s1_hs;
         s2_vs <= s1_vs;
         if (osd_on && px >= 16 && px < 80 && py >= 8 && py < 16) begin
            lit = bm[(py - 8) * 8 + (px - 16) / 8][7 - (px - 16) % 8];
            s2_r <= lit ? 6'd63 : s1_r >> 1;
            s2_g <= lit ? 6'd63 : s1_g >> 1;
            s2_b <= lit ? 6'd63 : s1_b >> 1;
         end else begin
            s2_r <= s1_r;
            s2_g <= s1_g;
            s2_b <= s1_b;
         end
         ypbpr_ref(s2_r, s2_g, s2_b, y, pb, pr);
         exp_r  <= mode_ypbpr ? 6'(pr) : s2_r;
         exp_g  <= mode_ypbpr ? 6'(y) : s2_g;
         exp_b  <= mode_ypbpr ? 6'(pb) : s2_b;
         exp_hs <= (mode_sd | mode_ypbpr) ? ~(s2_hs ^ s2_vs) : s2_hs;
         exp_vs <= (mode_sd | mode_ypbpr) ? 1'b1 : s2_vs;
      end
   end

   // outputs are registered, so the falling edge sees settled values
   always @(negedge clk) begin
      if (rst_n && vid_chk) begin
         chk_cnt++;
         assert (video_r == exp_r) else report_value("video_r_o", video_r, exp_r);
         assert (video_g == exp_g) else report_value("video_g_o", video_g, exp_g);
         assert (video_b == exp_b) else report_value("video_b_o", video_b, exp_b);
         assert (video_hs == exp_hs) else report_value("video_hs_o", video_hs, exp_hs);
         assert (video_vs == exp_vs) else report_value("video_vs_o", video_vs, exp_vs);
      end
   end

   always @(negedge clk) begin
      if (rst_n && ioctl_wr) begin
         chk_cnt++;
         assert (downloading) else report_text("ioctl write outside a download");
         if (wr_cnt >= dl_q.size()) begin
            report_text("more ioctl writes than bytes sent");
         end else begin
            assert (ioctl_addr == 22'(wr_cnt))
               else report_value("ioctl_addr_o", ioctl_addr, wr_cnt);
            assert (ioctl_data == dl_q[wr_cnt])
               else report_value("ioctl_data_o", ioctl_data, dl_q[wr_cnt]);
         end
         wr_cnt++;
      end
   end

   task automatic send_word(input logic [7:0] cmd, input logic [31:0] w);
      for (int i = 3; i >= 0; i--) begin
         tx_q.push_back(w[i*8 +: 8]);
      end
      send_command(0, cmd);
   endtask

   task automatic set_mode(input logic yp, input logic sd);
      vid_chk = 1'b0;
      tx_q.push_back({6'b0, sd, yp});
      send_command(0, mist_cfg_pkg::CMD_VMODE);
      mode_ypbpr = yp;
      mode_sd    = sd;
      repeat (16) @(negedge clk);
   endtask

   // game syncs active high and wider than the active low VGA syncs
   task automatic run_frame(input int lines, input int width);
      vid_chk = 1'b1;
      for (int ln = 0; ln < lines; ln++) begin
         for (int px = 0; px < width; px++) begin
            vga_hs = (px >= 4);
            vga_vs = (ln != 0);
            hs     = (px < 6);
            vs     = (ln < 2);
            game_r = 4'($random(seed));
            game_g = 4'($random(seed));
            game_b = 4'($random(seed));
            vga_r  = 6'($random(seed));
            vga_g  = 6'($random(seed));
            vga_b  = 6'($random(seed));
            repeat (2) @(negedge clk);
         end
      end
   endtask

   task automatic check_dac(input logic [15:0] sample);
      int ones;
      int expect_ones;
      ones = 0;
      expect_ones = sample * 1024 / 65536;
      snd = sample;
      repeat (64) @(negedge clk);
      repeat (1024) begin
         @(negedge clk);
         if (snd_pwm) ones++;
      end
      chk_cnt++;
      assert (ones >= expect_ones - 1 && ones <= expect_ones + 1)
         else report_value("snd_pwm_o ones", ones, expect_ones);
   endtask

   initial begin : timeout
      while (cycles < TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
   end

   initial begin : stimulus
      logic [31:0] w0, w1, ws;
      rst_n = 1'b0;
      pxl_cen = 1'b0;
      {game_r, game_g, game_b, vga_r, vga_g, vga_b} = '0;
      hs = 1'b0;
      vs = 1'b0;
      vga_hs = 1'b1;
      vga_vs = 1'b1;
      spi_di = 1'b0;
      spi_sck = 1'b0;
      {spi_ss2, spi_ss3, conf_data0} = 3'b111;
      snd = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      repeat (4) @(negedge clk);

      // control words, JOY0 lands on joystick2
      w0 = $random(seed);
      w1 = $random(seed);
      ws = $random(seed);
      send_word(mist_cfg_pkg::CMD_JOY0, w0);
      send_word(mist_cfg_pkg::CMD_JOY1, w1);
      send_word(mist_cfg_pkg::CMD_STATUS, ws);
      chk_cnt += 3;
      assert (joy2 == w0) else report_value("joystick2_o", joy2, w0);
      assert (joy1 == w1) else report_value("joystick1_o", joy1, w1);
      assert (status == ws) else report_value("status_o", status, ws);

      // ROM download of 20 bytes
      send_command(1, mist_cfg_pkg::CMD_DL_START);
      chk_cnt++;
      assert (downloading) else report_text("downloading_o low after START");
      for (int i = 0; i < 20; i++) begin
         tx_q.push_back(8'($random(seed)));
         dl_q.push_back(tx_q[i]);
      end
      send_command(1, mist_cfg_pkg::CMD_DL_DATA);
      send_command(1, mist_cfg_pkg::CMD_DL_END);
      chk_cnt += 2;
      assert (!downloading) else report_text("downloading_o high after END");
      assert (wr_cnt == 20) else report_value("ioctl_wr_o pulses", wr_cnt, 20);

      // native game video, composite sync
      set_mode(1'b0, 1'b1);
      run_frame(6, 100);
      // VGA source through YPbPr
      set_mode(1'b1, 1'b0);
      run_frame(6, 100);

      // OSD over plain VGA
      set_mode(1'b0, 1'b0);
      vid_chk = 1'b0;
      for (int i = 0; i < 64; i++) begin
         bm[i] = 8'($random(seed));
         tx_q.push_back(bm[i]);
      end
      send_command(2, mist_cfg_pkg::CMD_OSD_WR);
      send_command(2, mist_cfg_pkg::CMD_OSD_ON);
      osd_on = 1'b1;
      repeat (16) @(negedge clk);
      run_frame(20, 100);
      vid_chk = 1'b0;

      check_dac(16'h3000);
      check_dac(16'ha5a5);

      $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== src/jtgng_mist_base.sv ====
// MiST base board: control, ROM download, OSD video and sound
// single clk_sys domain; no SPI read-back, PS/2 or SD card
`timescale 1ns/1ps

module jtgng_mist_base #(
   parameter bit SIGNED_SND = 1'b0,
   parameter int OSD_X      = 16,
   parameter int OSD_Y      = 8
) (
   input  logic                       clk_sys_i,
   input  logic                       rst_n_i,
   input  logic                       pxl_cen_i,
   input  mist_video_pkg::game_col_t  game_r_i,
   input  mist_video_pkg::game_col_t  game_g_i,
   input  mist_video_pkg::game_col_t  game_b_i,
   input  logic                       hs_i,
   input  logic                       vs_i,
   input  mist_video_pkg::vga_col_t   vga_r_i,
   input  mist_video_pkg::vga_col_t   vga_g_i,
   input  mist_video_pkg::vga_col_t   vga_b_i,
   input  logic                       vga_hsync_i,
   input  logic                       vga_vsync_i,
   input  logic                       spi_di_i,
   input  logic                       spi_sck_i,
   input  logic                       spi_ss2_i,
   input  logic                       spi_ss3_i,
   input  logic                       conf_data0_i,
   output mist_video_pkg::vga_col_t   video_r_o,
   output mist_video_pkg::vga_col_t   video_g_o,
   output mist_video_pkg::vga_col_t   video_b_o,
   output logic                       video_hs_o,
   output logic                       video_vs_o,
   output mist_cfg_pkg::status_word_t status_o,
   output mist_cfg_pkg::joy_word_t    joystick1_o,
   output mist_cfg_pkg::joy_word_t    joystick2_o,
   input  logic [15:0]                snd_i,
   output logic                       snd_pwm_o,
   output mist_cfg_pkg::rom_addr_t    ioctl_addr_o,
   output mist_cfg_pkg::spi_byte_t    ioctl_data_o,
   output logic                       ioctl_wr_o,
   output logic                       downloading_o
);

   logic ypbpr;
   logic scandoubler_disable;

   mist_user_io u_user_io (
      .clk_sys_i (clk_sys_i), .rst_n_i (rst_n_i), .spi_sck_i (spi_sck_i),
      .conf_data0_i (conf_data0_i), .spi_di_i (spi_di_i),
      .joystick1_o (joystick1_o), .joystick2_o (joystick2_o), .status_o (status_o),
      .ypbpr_o (ypbpr), .scandoubler_disable_o (scandoubler_disable)
   );

   mist_data_io u_data_io (
      .clk_sys_i (clk_sys_i), .rst_n_i (rst_n_i), .spi_sck_i (spi_sck_i),
      .spi_ss2_i (spi_ss2_i), .spi_di_i (spi_di_i),
      .ioctl_addr_o (ioctl_addr_o), .ioctl_data_o (ioctl_data_o),
      .ioctl_wr_o (ioctl_wr_o), .downloading_o (downloading_o)
   );

   mist_video_out #(.OSD_X(OSD_X), .OSD_Y(OSD_Y)) u_video_out (
      .clk_sys_i (clk_sys_i), .rst_n_i (rst_n_i), .pxl_cen_i (pxl_cen_i),
      .spi_sck_i (spi_sck_i), .spi_ss3_i (spi_ss3_i), .spi_di_i (spi_di_i),
      .ypbpr_i (ypbpr), .scandoubler_disable_i (scandoubler_disable),
      .game_r_i (game_r_i), .game_g_i (game_g_i), .game_b_i (game_b_i),
      .hs_i (hs_i), .vs_i (vs_i),
      .vga_r_i (vga_r_i), .vga_g_i (vga_g_i), .vga_b_i (vga_b_i),
      .vga_hsync_i (vga_hsync_i), .vga_vsync_i (vga_vsync_i),
      .video_r_o (video_r_o), .video_g_o (video_g_o), .video_b_o (video_b_o),
      .video_hs_o (video_hs_o), .video_vs_o (video_vs_o)
   );

   sigma_delta_dac #(.SIGNED_SND(SIGNED_SND)) u_dac (
      .clk_sys_i (clk_sys_i),
      .rst_n_i   (rst_n_i),
      .snd_i     (snd_i),
      .snd_pwm_o (snd_pwm_o)
   );

endmodule

// ==== src/sigma_delta_dac.sv ====
// first-order 1-bit audio DAC, output is the accumulator carry
`timescale 1ns/1ps

module sigma_delta_dac #(
   parameter bit SIGNED_SND = 1'b0
) (
   input  logic        clk_sys_i,
   input  logic        rst_n_i,
   input  logic [15:0] snd_i,
   output logic        snd_pwm_o
);

   logic [15:0] acc_q;
   logic [16:0] sum;

   // signed samples become offset binary
   assign sum = {1'b0, acc_q} + {1'b0, snd_i[15] ^ SIGNED_SND, snd_i[14:0]};

   always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         acc_q     <= '0;
         snd_pwm_o <= 1'b0;
      end else begin
         acc_q     <= sum[15:0];
         snd_pwm_o <= sum[16];
      end
   end

endmodule

// ==== src/mist_video_out.sv ====
// video path: source select, OSD, then YPbPr or RGB with sync mode
// three pixel enables of latency on colour and sync
`timescale 1ns/1ps

module mist_video_out #(
   parameter int OSD_X = 16,
   parameter int OSD_Y = 8
) (
   input  logic                      clk_sys_i,
   input  logic                      rst_n_i,
   input  logic                      pxl_cen_i,
   input  logic                      spi_sck_i,
   input  logic                      spi_ss3_i,
   input  logic                      spi_di_i,
   input  logic                      ypbpr_i,
   input  logic                      scandoubler_disable_i,
   input  mist_video_pkg::game_col_t game_r_i,
   input  mist_video_pkg::game_col_t game_g_i,
   input  mist_video_pkg::game_col_t game_b_i,
   input  logic                      hs_i,
   input  logic                      vs_i,
   input  mist_video_pkg::vga_col_t  vga_r_i,
   input  mist_video_pkg::vga_col_t  vga_g_i,
   input  mist_video_pkg::vga_col_t  vga_b_i,
   input  logic                      vga_hsync_i,
   input  logic                      vga_vsync_i,
   output mist_video_pkg::vga_col_t  video_r_o,
   output mist_video_pkg::vga_col_t  video_g_o,
   output mist_video_pkg::vga_col_t  video_b_o,
   output logic                      video_hs_o,
   output logic                      video_vs_o
);

   mist_video_pkg::vga_col_t src_r_q, src_g_q, src_b_q;
   mist_video_pkg::vga_col_t osd_r, osd_g, osd_b;
   mist_video_pkg::vga_col_t rgb_r_q, rgb_g_q, rgb_b_q;
   mist_video_pkg::vga_col_t y_c, pb_c, pr_c;
   logic                     src_hs_q, src_vs_q, osd_hs, osd_vs, csync_mode;

   assign csync_mode = scandoubler_disable_i | ypbpr_i;

   always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         src_r_q    <= '0;
         src_g_q    <= '0;
         src_b_q    <= '0;
         src_hs_q   <= 1'b0;
         src_vs_q   <= 1'b0;
         rgb_r_q    <= '0;
         rgb_g_q    <= '0;
         rgb_b_q    <= '0;
         video_hs_o <= 1'b0;
         video_vs_o <= 1'b0;
      end else if (pxl_cen_i) begin
         if (scandoubler_disable_i) begin
            // 4-bit game colour, top bits repeated
            src_r_q  <= {game_r_i, game_r_i[3:2]};
            src_g_q  <= {game_g_i, game_g_i[3:2]};
            src_b_q  <= {game_b_i, game_b_i[3:2]};
            src_hs_q <= ~hs_i;
            src_vs_q <= ~vs_i;
         end else begin
            src_r_q  <= vga_r_i;
            src_g_q  <= vga_g_i;
            src_b_q  <= vga_b_i;
            src_hs_q <= vga_hsync_i;
            src_vs_q <= vga_vsync_i;
         end
         // matches the rgb2ypbpr register
         rgb_r_q <= osd_r;
         rgb_g_q <= osd_g;
         rgb_b_q <= osd_b;
         // composite sync and VS high for SCART cables
         video_hs_o <= csync_mode ? ~(osd_hs ^ osd_vs) : osd_hs;
         video_vs_o <= csync_mode ? 1'b1 : osd_vs;
      end
   end

   mist_osd #(.OSD_X(OSD_X), .OSD_Y(OSD_Y)) u_osd (
      .clk_sys_i (clk_sys_i),
      .rst_n_i   (rst_n_i),
      .pxl_cen_i (pxl_cen_i),
      .spi_sck_i (spi_sck_i),
      .spi_ss3_i (spi_ss3_i),
      .spi_di_i  (spi_di_i),
      .r_i       (src_r_q),
      .g_i       (src_g_q),
      .b_i       (src_b_q),
      .hs_i      (src_hs_q),
      .vs_i      (src_vs_q),
      .r_o       (osd_r),
      .g_o       (osd_g),
      .b_o       (osd_b),
      .hs_o      (osd_hs),
      .vs_o      (osd_vs)
   );

   rgb2ypbpr u_ypbpr (
      .clk_sys_i (clk_sys_i),
      .rst_n_i   (rst_n_i),
      .pxl_cen_i (pxl_cen_i),
      .red_i     (osd_r),
      .green_i   (osd_g),
      .blue_i    (osd_b),
      .y_o       (y_c),
      .pb_o      (pb_c),
      .pr_o      (pr_c)
   );

   assign video_r_o = ypbpr_i ? pr_c : rgb_r_q;
   assign video_g_o = ypbpr_i ? y_c  : rgb_g_q;
   assign video_b_o = ypbpr_i ? pb_c : rgb_b_q;

endmodule

// ==== src/rgb2ypbpr.sv ====
// registered RGB to YPbPr, 6-bit components
`timescale 1ns/1ps

module rgb2ypbpr (
   input  logic                     clk_sys_i,
   input  logic                     rst_n_i,
   input  logic                     pxl_cen_i,
   input  mist_video_pkg::vga_col_t red_i,
   input  mist_video_pkg::vga_col_t green_i,
   input  mist_video_pkg::vga_col_t blue_i,
   output mist_video_pkg::vga_col_t y_o,
   output mist_video_pkg::vga_col_t pb_o,
   output mist_video_pkg::vga_col_t pr_o
);

   logic [7:0]        y_sum;
   logic [5:0]        y_c;
   logic signed [8:0] pb_c, pr_c;

   function automatic logic [5:0] clamp6(input logic signed [8:0] v);
      if (v < 0) return 6'd0;
      else if (v > 63) return 6'd63;
      else return v[5:0];
   endfunction

   // Y = (R + 2G + B) / 4
   assign y_sum = {2'b0, red_i} + {1'b0, green_i, 1'b0} + {2'b0, blue_i};
   assign y_c   = y_sum[7:2];
   assign pb_c  = 9'sd32 + (($signed({3'b0, blue_i}) - $signed({3'b0, y_c})) >>> 1);
   assign pr_c  = 9'sd32 + (($signed({3'b0, red_i}) - $signed({3'b0, y_c})) >>> 1);

   always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         y_o  <= '0;
         pb_o <= '0;
         pr_o <= '0;
      end else if (pxl_cen_i) begin
         y_o  <= y_c;
         pb_o <= clamp6(pb_c);
         pr_o <= clamp6(pr_c);
      end
   end

endmodule

// ==== src/mist_osd.sv ====
// OSD overlay, 64x8 one-bit bitmap loaded over SPI_SS3
// syncs active low; x counts from HS fall, y from VS fall
`timescale 1ns/1ps

module mist_osd #(
   parameter int OSD_X = 16,
   parameter int OSD_Y = 8
) (
   input  logic                     clk_sys_i,
   input  logic                     rst_n_i,
   input  logic                     pxl_cen_i,
   input  logic                     spi_sck_i,
   input  logic                     spi_ss3_i,
   input  logic                     spi_di_i,
   input  mist_video_pkg::vga_col_t r_i,
   input  mist_video_pkg::vga_col_t g_i,
   input  mist_video_pkg::vga_col_t b_i,
   input  logic                     hs_i,
   input  logic                     vs_i,
   output mist_video_pkg::vga_col_t r_o,
   output mist_video_pkg::vga_col_t g_o,
   output mist_video_pkg::vga_col_t b_o,
   output logic                     hs_o,
   output logic                     vs_o
);

   mist_cfg_pkg::spi_byte_t   rx_byte;
   mist_cfg_pkg::spi_byte_t   cmd_q;
   mist_video_pkg::osd_addr_t rd_addr;
   logic [7:0]                bitmap [64];
   logic                      rx_vld;
   logic                      rx_first;
   logic                      osd_en_q;
   logic [6:0]                wr_cnt_q;
   logic                      wr_en;
   logic [9:0]                x_q, y_q, pix_x, pix_y, rel_x, rel_y;
   logic                      hs_fall, vs_fall, in_win, pix_on;

   mist_spi_rx u_rx (
      .clk_sys_i  (clk_sys_i),
      .rst_n_i    (rst_n_i),
      .sck_i      (spi_sck_i),
      .ss_i       (spi_ss3_i),
      .sdi_i      (spi_di_i),
      .byte_o     (rx_byte),
      .byte_vld_o (rx_vld),
      .first_o    (rx_first)
   );

   assign wr_en = rx_vld && !rx_first && cmd_q == mist_cfg_pkg::CMD_OSD_WR && !wr_cnt_q[6];

   always_ff @(posedge clk_sys_i) begin
      if (wr_en) begin
         bitmap[wr_cnt_q[5:0]] <= rx_byte;
      end
   end

   // hs_o and vs_o double as the previous sync levels
   assign hs_fall = hs_o & ~hs_i;
   assign vs_fall = vs_o & ~vs_i;
   assign pix_x   = hs_fall ? '0 : x_q;
   assign pix_y   = vs_fall ? '0 : (hs_fall ? y_q + 10'd1 : y_q);
   assign rel_x   = pix_x - 10'(OSD_X);
   assign rel_y   = pix_y - 10'(OSD_Y);
   assign in_win  = pix_x >= 10'(OSD_X) && pix_x < 10'(OSD_X + mist_video_pkg::OSD_W) &&
                    pix_y >= 10'(OSD_Y) && pix_y < 10'(OSD_Y + mist_video_pkg::OSD_H);
   // line times 8 plus byte column
   assign rd_addr = {rel_y[2:0], rel_x[5:3]};
   assign pix_on  = bitmap[rd_addr][3'd7 - rel_x[2:0]];

   always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cmd_q    <= '0;
         osd_en_q <= 1'b0;
         wr_cnt_q <= '0;
         x_q      <= '0;
         y_q      <= '0;
         r_o      <= '0;
         g_o      <= '0;
         b_o      <= '0;
         hs_o     <= 1'b0;
         vs_o     <= 1'b0;
      end else begin
         if (rx_vld && rx_first) begin
            cmd_q    <= rx_byte;
            wr_cnt_q <= '0;
            if (rx_byte == mist_cfg_pkg::CMD_OSD_ON) osd_en_q <= 1'b1;
            if (rx_byte == mist_cfg_pkg::CMD_OSD_OFF) osd_en_q <= 1'b0;
         end else if (wr_en) begin
            wr_cnt_q <= wr_cnt_q + 7'd1;
         end
         if (pxl_cen_i) begin
            x_q  <= pix_x + 10'd1;
            y_q  <= pix_y;
            hs_o <= hs_i;
            vs_o <= vs_i;
            if (osd_en_q && in_win) begin
               // set bit is white, clear bit dims the picture
               r_o <= pix_on ? 6'd63 : {1'b0, r_i[5:1]};
               g_o <= pix_on ? 6'd63 : {1'b0, g_i[5:1]};
               b_o <= pix_on ? 6'd63 : {1'b0, b_i[5:1]};
            end else begin
               r_o <= r_i;
               g_o <= g_i;
               b_o <= b_i;
            end
         end
      end
   end

endmodule

// ==== src/mist_data_io.sv ====
// ROM download channel on SPI_SS2
// no back-pressure, the consumer must take every write pulse
`timescale 1ns/1ps

module mist_data_io (
   input  logic                    clk_sys_i,
   input  logic                    rst_n_i,
   input  logic                    spi_sck_i,
   input  logic                    spi_ss2_i,
   input  logic                    spi_di_i,
   output mist_cfg_pkg::rom_addr_t ioctl_addr_o,
   output mist_cfg_pkg::spi_byte_t ioctl_data_o,
   output logic                    ioctl_wr_o,
   output logic                    downloading_o
);

   mist_cfg_pkg::spi_byte_t rx_byte;
   mist_cfg_pkg::spi_byte_t cmd_q;
   mist_cfg_pkg::rom_addr_t next_addr_q;
   logic                    rx_vld;
   logic                    rx_first;

   mist_spi_rx u_rx (
      .clk_sys_i  (clk_sys_i),
      .rst_n_i    (rst_n_i),
      .sck_i      (spi_sck_i),
      .ss_i       (spi_ss2_i),
      .sdi_i      (spi_di_i),
      .byte_o     (rx_byte),
      .byte_vld_o (rx_vld),
      .first_o    (rx_first)
   );

   always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cmd_q         <= '0;
         next_addr_q   <= '0;
         ioctl_addr_o  <= '0;
         ioctl_wr_o    <= 1'b0;
         downloading_o <= 1'b0;
      end else begin
         ioctl_wr_o <= 1'b0;
         if (rx_vld && rx_first) begin
            cmd_q <= rx_byte;
            if (rx_byte == mist_cfg_pkg::CMD_DL_START) begin
               downloading_o <= 1'b1;
               next_addr_q   <= '0;
               ioctl_addr_o  <= '0;
            end
            if (rx_byte == mist_cfg_pkg::CMD_DL_END) begin
               downloading_o <= 1'b0;
            end
         end else if (rx_vld && cmd_q == mist_cfg_pkg::CMD_DL_DATA) begin
            // address of this byte stays put until the next one
            ioctl_wr_o   <= 1'b1;
            ioctl_addr_o <= next_addr_q;
            next_addr_q  <= next_addr_q + 22'd1;
         end
      end
   end

   always_ff @(posedge clk_sys_i) begin
      if (rx_vld && !rx_first && cmd_q == mist_cfg_pkg::CMD_DL_DATA) begin
         ioctl_data_o <= rx_byte;
      end
   end

endmodule

// ==== src/mist_user_io.sv ====
// control channel on CONF_DATA0: joysticks, status and video mode
// bytes past a command's payload are ignored
`timescale 1ns/1ps

module mist_user_io (
   input  logic                       clk_sys_i,
   input  logic                       rst_n_i,
   input  logic                       spi_sck_i,
   input  logic                       conf_data0_i,
   input  logic                       spi_di_i,
   output mist_cfg_pkg::joy_word_t    joystick1_o,
   output mist_cfg_pkg::joy_word_t    joystick2_o,
   output mist_cfg_pkg::status_word_t status_o,
   output logic                       ypbpr_o,
   output logic                       scandoubler_disable_o
);

   mist_cfg_pkg::spi_byte_t rx_byte;
   mist_cfg_pkg::spi_byte_t cmd_q;
   logic                    rx_vld;
   logic                    rx_first;
   logic [2:0]              cnt_q;
   logic [23:0]             shadow_q;

   mist_spi_rx u_rx (
      .clk_sys_i  (clk_sys_i),
      .rst_n_i    (rst_n_i),
      .sck_i      (spi_sck_i),
      .ss_i       (conf_data0_i),
      .sdi_i      (spi_di_i),
      .byte_o     (rx_byte),
      .byte_vld_o (rx_vld),
      .first_o    (rx_first)
   );

   always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cmd_q                 <= '0;
         cnt_q                 <= '0;
         joystick1_o           <= '0;
         joystick2_o           <= '0;
         status_o              <= '0;
         ypbpr_o               <= 1'b0;
         scandoubler_disable_o <= 1'b0;
      end else if (rx_vld) begin
         if (rx_first) begin
            cmd_q <= rx_byte;
            cnt_q <= '0;
         end else begin
            // saturate so trailing bytes never commit again
            if (cnt_q != 3'd7) begin
               cnt_q <= cnt_q + 3'd1;
            end
            if (cnt_q == 3'd3) begin
               // joystick numbering is swapped on the firmware side
               case (cmd_q)
                  mist_cfg_pkg::CMD_JOY0:   joystick2_o <= {shadow_q, rx_byte};
                  mist_cfg_pkg::CMD_JOY1:   joystick1_o <= {shadow_q, rx_byte};
                  mist_cfg_pkg::CMD_STATUS: status_o    <= {shadow_q, rx_byte};
                  default: ;
               endcase
            end
            if (cnt_q == 3'd0 && cmd_q == mist_cfg_pkg::CMD_VMODE) begin
               ypbpr_o               <= rx_byte[0];
               scandoubler_disable_o <= rx_byte[1];
            end
         end
      end
   end

   // first three payload bytes, MSB first
   always_ff @(posedge clk_sys_i) begin
      if (rx_vld && !rx_first) begin
         shadow_q <= {shadow_q[15:0], rx_byte};
      end
   end

endmodule

// ==== src/mist_spi_rx.sv ====
// SPI mode 0 byte receiver, SCK oversampled on clk_sys
// SCK period must be at least 8 clk_sys cycles
`timescale 1ns/1ps

module mist_spi_rx (
   input  logic                  clk_sys_i,
   input  logic                  rst_n_i,
   input  logic                  sck_i,
   input  logic                  ss_i,
   input  logic                  sdi_i,
   output mist_cfg_pkg::spi_byte_t byte_o,
   output logic                  byte_vld_o,
   output logic                  first_o
);

   logic [2:0] sck_q;
   logic [1:0] ss_q;
   logic [1:0] sdi_q;
   logic [2:0] bit_cnt_q;
   logic [6:0] shift_q;
   logic       sck_rise;

   // third SCK flop only serves edge detection
   assign sck_rise = sck_q[1] & ~sck_q[2];

   always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sck_q      <= '0;
         ss_q       <= 2'b11;
         sdi_q      <= '0;
         bit_cnt_q  <= '0;
         byte_vld_o <= 1'b0;
         first_o    <= 1'b1;
      end else begin
         sck_q      <= {sck_q[1:0], sck_i};
         ss_q       <= {ss_q[0], ss_i};
         sdi_q      <= {sdi_q[0], sdi_i};
         byte_vld_o <= 1'b0;
         if (ss_q[1]) begin
            // deselect drops a partial byte and restarts framing
            bit_cnt_q <= '0;
            first_o   <= 1'b1;
         end else begin
            if (byte_vld_o) begin
               first_o <= 1'b0;
            end
            if (sck_rise) begin
               bit_cnt_q <= bit_cnt_q + 3'd1;
               if (bit_cnt_q == 3'd7) begin
                  byte_vld_o <= 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk_sys_i) begin
      if (!ss_q[1] && sck_rise) begin
         shift_q <= {shift_q[5:0], sdi_q[1]};
         if (bit_cnt_q == 3'd7) begin
            byte_o <= {shift_q, sdi_q[1]};
         end
      end
   end

endmodule

// ==== src/mist_video_pkg.sv ====
// colour widths and OSD window geometry
// the OSD bitmap is one bit per pixel, 8 bytes per line
package mist_video_pkg;

   typedef logic [3:0] game_col_t;
   typedef logic [5:0] vga_col_t;

   // window size in pixels and lines
   localparam int OSD_W = 64;
   localparam int OSD_H = 8;

   // byte address into the 64-byte bitmap
   typedef logic [5:0] osd_addr_t;

endpackage

// ==== src/mist_cfg_pkg.sv ====
// control types and SPI command codes from the ARM I/O controller
// payload lengths are fixed by the firmware, not checked here
package mist_cfg_pkg;

   typedef logic [7:0]  spi_byte_t;
   typedef logic [31:0] joy_word_t;
   typedef logic [31:0] status_word_t;
   typedef logic [21:0] rom_addr_t;

   // control channel, four payload bytes MSB first
   localparam spi_byte_t CMD_JOY0     = 8'h02;
   localparam spi_byte_t CMD_JOY1     = 8'h03;
   localparam spi_byte_t CMD_STATUS   = 8'h1e;
   // one byte: bit 0 ypbpr, bit 1 scandoubler disable
   localparam spi_byte_t CMD_VMODE    = 8'h1f;

   // download channel
   localparam spi_byte_t CMD_DL_START = 8'h54;
   localparam spi_byte_t CMD_DL_END   = 8'h55;
   localparam spi_byte_t CMD_DL_DATA  = 8'h56;

   // OSD channel, the write carries 64 bitmap bytes
   localparam spi_byte_t CMD_OSD_OFF  = 8'h40;
   localparam spi_byte_t CMD_OSD_ON   = 8'h41;
   localparam spi_byte_t CMD_OSD_WR   = 8'h20;

endpackage
